// File: sdram_cmd_pkg.sv
`default_nettype none

package sdram_cmd_pkg;

	// pin order {csn, rasn, casn, wen}
	typedef enum logic [3:0] {
		NOP       = 4'b1111,
		ACTIVE    = 4'b0011,
		READ      = 4'b0101,
		WRITE     = 4'b0100,
		PRECHARGE = 4'b0010,
		REFRESH   = 4'b0001,
		MODE_SET  = 4'b0000
	} sdram_cmd_t;

	// cas latency 3, sequential, burst length 1
	localparam logic [11:0] mode_reg_val = 12'h030;
	localparam int cas_latency = 3;

	// refreshes issued during power-up
	localparam int init_ref_count = 8;

	// auto-precharge on read/write, all banks on precharge
	localparam int ap_bit = 10;

	// nop cycles after each command
	localparam int trp_nops = 1;
	localparam int init_ref_nops = 2;
	localparam int trcd_nops = 1;
	// capture at cas latency, one more cycle to hand data back
	localparam int rd_nops = cas_latency + 1;
	// covers write recovery plus auto-precharge
	localparam int wr_nops = 6;
	localparam int ref_nops = 5;

	// wide enough for the longest nop run
	localparam int dly_w = 3;

endpackage

`default_nettype wire

// File: sdram_addr_pkg.sv
`default_nettype none

package sdram_addr_pkg;

	// device geometry
	localparam int bank_w = 2;
	localparam int row_w = 12;
	localparam int col_w = 8;
	localparam int avl_addr_w = bank_w + row_w + col_w;

	// data path
	localparam int data_w = 16;
	localparam int be_w = data_w / 8;

	// word address split, bank on top
	typedef struct packed {
		logic [bank_w-1:0] bank;
		logic [row_w-1:0]  row;
		logic [col_w-1:0]  col;
	} sdram_addr_fields_t;

	// same word seen flat or split
	typedef union packed {
		sdram_addr_fields_t          fields;
		logic [avl_addr_w-1:0]       raw;
	} sdram_addr_u;

endpackage

`default_nettype wire

// File: sdram_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface sdram_req_if;

	// request side, held from capture until done
	logic                                wr_pend;
	logic                                rd_pend;
	sdram_addr_pkg::sdram_addr_u         addr;
	logic [sdram_addr_pkg::data_w-1:0]   wdata;
	logic [sdram_addr_pkg::be_w-1:0]     byte_en;

	// completion side
	// done is a single-cycle pulse
	logic                                done;
	logic [sdram_addr_pkg::data_w-1:0]   rdata;

	modport port (
		output wr_pend, rd_pend, addr, wdata, byte_en,
		input  done, rdata
	);

	modport engine (
		input  wr_pend, rd_pend, addr, wdata, byte_en,
		output done, rdata
	);

endinterface

`default_nettype wire

// File: avl_slave_port.sv
`timescale 1ns/1ps
`default_nettype none

module avl_slave_port (
	input  logic                                    sys_clk,
	input  logic                                    rstn,
	input  logic [sdram_addr_pkg::avl_addr_w-1:0]   avl_addr,
	input  logic [sdram_addr_pkg::be_w-1:0]         avl_byte_en,
	input  logic                                    avl_write,
	input  logic                                    avl_read,
	input  logic [sdram_addr_pkg::data_w-1:0]       avl_wrdata,
	output logic [sdram_addr_pkg::data_w-1:0]       avl_rddata,
	output logic                                    avl_waitrequest,
	sdram_req_if.port                               req
);

	logic busy;

	// one request at a time
	assign busy = req.wr_pend | req.rd_pend;

	// pending flags
	// write wins if a master wrongly raises both
	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			req.wr_pend <= 1'b0;
			req.rd_pend <= 1'b0;
		end else if (req.done) begin
			// engine finished, free the slot
			req.wr_pend <= 1'b0;
			req.rd_pend <= 1'b0;
		end else if (!busy) begin
			req.wr_pend <= avl_write;
			req.rd_pend <= avl_read & ~avl_write;
		end
	end

	// request fields track the bus while free
	// frozen once a flag is up
	always_ff @(posedge sys_clk) begin
		if (!busy) begin
			req.addr.raw <= avl_addr;
			req.wdata <= avl_wrdata;
			req.byte_en <= avl_byte_en;
		end
	end

	// master is released only on the completion cycle
	assign avl_waitrequest = ~req.done;

	// engine already registers the read word
	assign avl_rddata = req.rdata;

endmodule

`default_nettype wire

// File: sdram_refresh_timer.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_refresh_timer #(
	parameter int init_cycles = 10000,
	parameter int refresh_interval = 390
) (
	input  logic sys_clk,
	input  logic rstn,
	input  logic refresh_ack,
	output logic pwr_up_done,
	output logic refresh_due
);

	localparam int pw = $clog2(init_cycles + 1);
	localparam int rw = $clog2(refresh_interval + 1);
	localparam logic [pw-1:0] pwr_max = pw'(init_cycles);
	// count 0 is the refresh cycle itself
	// so an idle engine refreshes every refresh_interval cycles
	localparam logic [rw-1:0] ref_max = rw'(refresh_interval - 1);

	logic [pw-1:0] pwr_cnt;
	logic [rw-1:0] ref_cnt;

	// power-up wait, stops at the limit
	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			pwr_cnt <= '0;
		end else if (pwr_cnt != pwr_max) begin
			pwr_cnt <= pwr_cnt + 1'b1;
		end
	end

	assign pwr_up_done = (pwr_cnt == pwr_max);

	// refresh interval
	// runs from reset, so the first refresh can be due right after init
	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			ref_cnt <= '0;
		end else if (refresh_ack) begin
			ref_cnt <= rw'(1);
		end else if (ref_cnt != ref_max) begin
			// hold at the limit until the engine gets to it
			ref_cnt <= ref_cnt + 1'b1;
		end
	end

	assign refresh_due = (ref_cnt == ref_max);

endmodule

`default_nettype wire

// File: sdram_cmd_engine.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_cmd_engine (
	input  logic                                 sys_clk,
	input  logic                                 rstn,
	input  logic                                 pwr_up_done,
	input  logic                                 refresh_due,
	output logic                                 refresh_ack,
	sdram_req_if.engine                          req,
	output logic                                 sdram_csn,
	output logic                                 sdram_rasn,
	output logic                                 sdram_casn,
	output logic                                 sdram_wen,
	output logic [sdram_addr_pkg::bank_w-1:0]    sdram_ba,
	output logic [sdram_addr_pkg::row_w-1:0]     sdram_a,
	output logic [sdram_addr_pkg::be_w-1:0]      sdram_dqm,
	inout  wire  [sdram_addr_pkg::data_w-1:0]    sdram_dq
);

	localparam int dw = sdram_cmd_pkg::dly_w;
	localparam int irw = $clog2(sdram_cmd_pkg::init_ref_count);

	// init states
	localparam logic [3:0] st_pwr    = 4'd0;
	localparam logic [3:0] st_pall   = 4'd1;
	localparam logic [3:0] st_pall_w = 4'd2;
	localparam logic [3:0] st_iref   = 4'd3;
	localparam logic [3:0] st_iref_w = 4'd4;
	localparam logic [3:0] st_mode   = 4'd5;
	// traffic states
	localparam logic [3:0] st_idle   = 4'd6;
	localparam logic [3:0] st_act    = 4'd7;
	localparam logic [3:0] st_act_w  = 4'd8;
	localparam logic [3:0] st_rd     = 4'd9;
	localparam logic [3:0] st_rd_w   = 4'd10;
	localparam logic [3:0] st_wr     = 4'd11;
	localparam logic [3:0] st_wr_w   = 4'd12;
	localparam logic [3:0] st_ref    = 4'd13;
	localparam logic [3:0] st_ref_w  = 4'd14;

	logic [3:0] state;
	logic [3:0] next_state;
	logic [dw-1:0] dly_cnt;
	logic [irw-1:0] init_ref_cnt;
	logic dly_end;
	logic dq_oe;
	logic [sdram_addr_pkg::row_w-1:0] col_addr;
	sdram_cmd_pkg::sdram_cmd_t cmd;

	// current nop run finished
	assign dly_end = (dly_cnt == '0);

	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			state <= st_pwr;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			st_pwr:    if (pwr_up_done) next_state = st_pall;
			st_pall:   next_state = st_pall_w;
			st_pall_w: if (dly_end) next_state = st_iref;
			st_iref:   next_state = st_iref_w;
			st_iref_w: begin
				if (dly_end) begin
					// eighth refresh done, load the mode register
					if (init_ref_cnt == irw'(sdram_cmd_pkg::init_ref_count - 1)) begin
						next_state = st_mode;
					end else begin
						next_state = st_iref;
					end
				end
			end
			st_mode:   next_state = st_idle;
			st_idle: begin
				// refresh beats any waiting request
				if (refresh_due) begin
					next_state = st_ref;
				end else if (req.wr_pend || req.rd_pend) begin
					next_state = st_act;
				end
			end
			st_act:    next_state = st_act_w;
			st_act_w: begin
				if (dly_end) begin
					next_state = req.wr_pend ? st_wr : st_rd;
				end
			end
			st_rd:     next_state = st_rd_w;
			st_rd_w:   if (dly_end) next_state = st_idle;
			st_wr:     next_state = st_wr_w;
			st_wr_w:   if (dly_end) next_state = st_idle;
			st_ref:    next_state = st_ref_w;
			st_ref_w:  if (dly_end) next_state = st_idle;
			default:   next_state = st_idle;
		endcase
	end

	// nop run length, loaded on entry to each wait state
	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			dly_cnt <= '0;
		end else if (next_state != state) begin
			case (next_state)
				st_pall_w: dly_cnt <= dw'(sdram_cmd_pkg::trp_nops - 1);
				st_iref_w: dly_cnt <= dw'(sdram_cmd_pkg::init_ref_nops - 1);
				st_act_w:  dly_cnt <= dw'(sdram_cmd_pkg::trcd_nops - 1);
				st_rd_w:   dly_cnt <= dw'(sdram_cmd_pkg::rd_nops - 1);
				st_wr_w:   dly_cnt <= dw'(sdram_cmd_pkg::wr_nops - 1);
				st_ref_w:  dly_cnt <= dw'(sdram_cmd_pkg::ref_nops - 1);
				default:   dly_cnt <= '0;
			endcase
		end else if (!dly_end) begin
			dly_cnt <= dly_cnt - 1'b1;
		end
	end

	// counts finished init refreshes
	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			init_ref_cnt <= '0;
		end else if (state == st_iref_w && dly_end) begin
			init_ref_cnt <= init_ref_cnt + 1'b1;
		end
	end

	// command decode
	always_comb begin
		case (state)
			st_pall:          cmd = sdram_cmd_pkg::PRECHARGE;
			st_iref, st_ref:  cmd = sdram_cmd_pkg::REFRESH;
			st_mode:          cmd = sdram_cmd_pkg::MODE_SET;
			st_act:           cmd = sdram_cmd_pkg::ACTIVE;
			st_rd:            cmd = sdram_cmd_pkg::READ;
			st_wr:            cmd = sdram_cmd_pkg::WRITE;
			default:          cmd = sdram_cmd_pkg::NOP;
		endcase
	end

	assign {sdram_csn, sdram_rasn, sdram_casn, sdram_wen} = cmd;

	// only periodic refreshes restart the interval
	assign refresh_ack = (state == st_ref);

	// column plus auto-precharge
	always_comb begin
		col_addr = '0;
		col_addr[sdram_addr_pkg::col_w-1:0] = req.addr.fields.col;
		col_addr[sdram_cmd_pkg::ap_bit] = 1'b1;
	end

	// address and bank per command
	always_comb begin
		sdram_a = '0;
		sdram_ba = '0;
		case (state)
			st_act: begin
				sdram_a = req.addr.fields.row;
				sdram_ba = req.addr.fields.bank;
			end
			st_rd, st_wr: begin
				sdram_a = col_addr;
				sdram_ba = req.addr.fields.bank;
			end
			// a10 high, all banks
			st_pall:  sdram_a[sdram_cmd_pkg::ap_bit] = 1'b1;
			st_mode:  sdram_a = sdram_cmd_pkg::mode_reg_val;
			default:  sdram_a = '0;
		endcase
	end

	// data bus is driven from activate through the cycle after write
	assign dq_oe = (req.wr_pend && (state == st_act || state == st_act_w))
		|| (state == st_wr)
		|| (state == st_wr_w && dly_cnt == dw'(sdram_cmd_pkg::wr_nops - 1));

	assign sdram_dq = dq_oe ? req.wdata : {sdram_addr_pkg::data_w{1'bz}};

	// lanes masked by byte enables on writes, open otherwise
	assign sdram_dqm = dq_oe ? ~req.byte_en : '0;

	// read word lands cas_latency cycles after the read command
	always_ff @(posedge sys_clk) begin
		if (state == st_rd_w
			&& dly_cnt == dw'(sdram_cmd_pkg::rd_nops - 1 - sdram_cmd_pkg::cas_latency + 1)) begin
			req.rdata <= sdram_dq;
		end
	end

	// completion on the last nop of a read or write
	assign req.done = (state == st_rd_w || state == st_wr_w) && dly_end;

endmodule

`default_nettype wire

// File: sdram_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_subsys #(
	parameter int init_cycles = 10000,
	parameter int refresh_interval = 390
) (
	input  logic                                    sys_clk,
	input  logic                                    rstn,
	// avalon-mm slave
	input  logic [sdram_addr_pkg::avl_addr_w-1:0]   avl_addr,
	input  logic [sdram_addr_pkg::be_w-1:0]         avl_byte_en,
	input  logic                                    avl_write,
	input  logic                                    avl_read,
	input  logic [sdram_addr_pkg::data_w-1:0]       avl_wrdata,
	output logic [sdram_addr_pkg::data_w-1:0]       avl_rddata,
	output logic                                    avl_waitrequest,
	// sdram pins
	output logic                                    sdram_csn,
	output logic                                    sdram_rasn,
	output logic                                    sdram_casn,
	output logic                                    sdram_wen,
	output logic [sdram_addr_pkg::bank_w-1:0]       sdram_ba,
	output logic [sdram_addr_pkg::row_w-1:0]        sdram_a,
	inout  wire  [sdram_addr_pkg::data_w-1:0]       sdram_dq,
	output logic [sdram_addr_pkg::be_w-1:0]         sdram_dqm
);

	logic pwr_up_done;
	logic refresh_due;
	logic refresh_ack;

	// held request between port and engine
	sdram_req_if req_if ();

	avl_slave_port port_i (
		.sys_clk         (sys_clk),
		.rstn            (rstn),
		.avl_addr        (avl_addr),
		.avl_byte_en     (avl_byte_en),
		.avl_write       (avl_write),
		.avl_read        (avl_read),
		.avl_wrdata      (avl_wrdata),
		.avl_rddata      (avl_rddata),
		.avl_waitrequest (avl_waitrequest),
		.req             (req_if.port)
	);

	sdram_refresh_timer #(
		.init_cycles      (init_cycles),
		.refresh_interval (refresh_interval)
	) timer_i (
		.sys_clk     (sys_clk),
		.rstn        (rstn),
		.refresh_ack (refresh_ack),
		.pwr_up_done (pwr_up_done),
		.refresh_due (refresh_due)
	);

	sdram_cmd_engine engine_i (
		.sys_clk     (sys_clk),
		.rstn        (rstn),
		.pwr_up_done (pwr_up_done),
		.refresh_due (refresh_due),
		.refresh_ack (refresh_ack),
		.req         (req_if.engine),
		.sdram_csn   (sdram_csn),
		.sdram_rasn  (sdram_rasn),
		.sdram_casn  (sdram_casn),
		.sdram_wen   (sdram_wen),
		.sdram_ba    (sdram_ba),
		.sdram_a     (sdram_a),
		.sdram_dqm   (sdram_dqm),
		.sdram_dq    (sdram_dq)
	);

endmodule

`default_nettype wire

// File: sdram_model.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_model (
	input  logic        sys_clk,
	input  logic        csn,
	input  logic        rasn,
	input  logic        casn,
	input  logic        wen,
	input  logic [1:0]  ba,
	input  logic [11:0] a,
	input  logic [1:0]  dqm,
	inout  wire  [15:0] dq
);

	// sparse storage keyed by {bank, row, col}
	logic [15:0] mem [int];
	// row latched per bank at activate
	logic [11:0] open_row [4];
	// cas latency pipe, stage 2 drives the bus
	logic [2:0]  rd_vld = '0;
	logic [15:0] rd_data [3];
	logic [15:0] old_word;
	int key;
	sdram_cmd_pkg::sdram_cmd_t cmd;

	assign cmd = sdram_cmd_pkg::sdram_cmd_t'({csn, rasn, casn, wen});

	// data valid in the third cycle after read
	assign dq = rd_vld[2] ? rd_data[2] : 16'bz;

	always @(posedge sys_clk) begin
		rd_vld <= {rd_vld[1:0], cmd == sdram_cmd_pkg::READ};
		rd_data[1] <= rd_data[0];
		rd_data[2] <= rd_data[1];
		key = {ba, open_row[ba], a[7:0]};
		case (cmd)
			sdram_cmd_pkg::ACTIVE: open_row[ba] <= a;
			sdram_cmd_pkg::READ: rd_data[0] <= mem.exists(key) ? mem[key] : 16'h0000;
			sdram_cmd_pkg::WRITE: begin
				old_word = mem.exists(key) ? mem[key] : 16'h0000;
				// dqm high keeps the stored byte
				mem[key] = {dqm[1] ? old_word[15:8] : dq[15:8],
					dqm[0] ? old_word[7:0] : dq[7:0]};
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: tb_sdram_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_checker #(
	parameter int init_cycles = 200,
	parameter int refresh_interval = 390,
	parameter int max_lines = 32
) (
	input  logic        sys_clk,
	input  logic        rstn,
	input  logic [21:0] avl_addr,
	input  logic [1:0]  avl_byte_en,
	input  logic        avl_write,
	input  logic        avl_read,
	input  logic [15:0] avl_rddata,
	input  logic        avl_waitrequest,
	input  logic [3:0]  cmd,
	input  logic [1:0]  sdram_ba,
	input  logic [11:0] sdram_a,
	input  logic [1:0]  sdram_dqm,
	output int          data_errs,
	output int          proto_errs
);

	// expected init values
	localparam int exp_init_refs = 8;
	localparam logic [11:0] exp_mode = 12'h030;
	// longest access adds to the allowed refresh gap
	localparam int max_gap = refresh_interval + 9;

	logic [67:0] lines [max_lines];
	logic init_pall;
	logic init_done;
	int cyc;
	int acc_idx;
	int init_refs;
	int last_ref;

	function automatic string test_name(input logic [3:0] id);
		case (id)
			4'h1: return "full_write_read";
			4'h2: return "byte_enable_merge";
			4'h3: return "address_decode";
			4'h4: return "mixed_fields";
			default: return "unnamed";
		endcase
	endfunction

	task automatic value_error(input string name, input string what, input logic [31:0] exp_v,
		input logic [31:0] act_v, input logic is_data);
		$display("[ERROR] %s %s: expected %h, actual %h", name, what, exp_v, act_v);
		if (is_data) data_errs++;
		else proto_errs++;
	endtask

	task automatic protocol_error(input string msg);
		$display("protocol error at cycle %0d: %s", cyc, msg);
		proto_errs++;
	endtask

	initial begin
		data_errs = 0;
		proto_errs = 0;
		for (int i = 0; i < max_lines; i++) lines[i] = '0;
		$readmemh("sdram_testdata.txt", lines);
	end

	always @(posedge sys_clk) begin
		if (!rstn) begin
			cyc = 0;
			acc_idx = 0;
			init_refs = 0;
			last_ref = 0;
			init_pall = 1'b0;
			init_done = 1'b0;
		end else begin
			cyc = cyc + 1;
			// power-up wait
			if (cmd != sdram_cmd_pkg::NOP && cyc <= init_cycles)
				protocol_error($sformatf("command %b before power-up wait ended", cmd));
			if (!init_done) begin
				if (!avl_waitrequest) protocol_error("waitrequest low during init");
				case (cmd)
					sdram_cmd_pkg::NOP: ;
					sdram_cmd_pkg::PRECHARGE: begin
						if (init_pall || !sdram_a[10])
							protocol_error("init precharge repeated or without a10");
						init_pall = 1'b1;
					end
					sdram_cmd_pkg::REFRESH: begin
						if (!init_pall) protocol_error("init refresh before precharge");
						init_refs++;
						last_ref = cyc;
					end
					sdram_cmd_pkg::MODE_SET: begin
						if (init_refs != exp_init_refs)
							value_error("init_sequence", "refresh count", exp_init_refs,
								init_refs, 1'b0);
						if ({sdram_ba, sdram_a} != {2'b00, exp_mode})
							value_error("init_sequence", "mode set ba/a", {2'b00, exp_mode},
								{sdram_ba, sdram_a}, 1'b0);
						init_done = 1'b1;
					end
					default: protocol_error($sformatf("command %b during init", cmd));
				endcase
			end else begin
				// periodic refresh overdue
				if (cyc - last_ref > max_gap) begin
					protocol_error($sformatf("no refresh for %0d cycles", cyc - last_ref));
					last_ref = cyc;
				end
				case (cmd)
					sdram_cmd_pkg::NOP: ;
					sdram_cmd_pkg::REFRESH: last_ref = cyc;
					// row and bank straight from the held address
					sdram_cmd_pkg::ACTIVE:
						if ({sdram_ba, sdram_a} !== avl_addr[21:8])
							value_error(test_name(lines[acc_idx][67:64]), "activate ba/row",
								avl_addr[21:8], {sdram_ba, sdram_a}, 1'b0);
					sdram_cmd_pkg::READ, sdram_cmd_pkg::WRITE: begin
						if ({sdram_ba, sdram_a[10], sdram_a[7:0]} !== {avl_addr[21:20], 1'b1,
							avl_addr[7:0]})
							value_error(test_name(lines[acc_idx][67:64]), "ba/a10/col",
								{avl_addr[21:20], 1'b1, avl_addr[7:0]},
								{sdram_ba, sdram_a[10], sdram_a[7:0]}, 1'b0);
						// dqm masks the lanes not enabled
						if (cmd == sdram_cmd_pkg::WRITE && sdram_dqm !== ~avl_byte_en)
							value_error(test_name(lines[acc_idx][67:64]), "write dqm",
								~avl_byte_en, sdram_dqm, 1'b0);
					end
					default: protocol_error($sformatf("unexpected command %b after init", cmd));
				endcase
			end
			// completion cycle
			if (!avl_waitrequest) begin
				if (!avl_read && !avl_write) begin
					protocol_error("waitrequest low with no request held");
				end else begin
					if (avl_read && avl_rddata !== lines[acc_idx][15:0])
						value_error(test_name(lines[acc_idx][67:64]), "read data",
							lines[acc_idx][15:0], avl_rddata, 1'b1);
					if (acc_idx < max_lines - 1) acc_idx++;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: sdram_subsys_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_subsys_assertions (
	input logic       sys_clk,
	input logic       rstn,
	input logic       pwr_up_done,
	input logic       done,
	input logic       wr_pend,
	input logic       dq_oe,
	input logic [3:0] cmd
);

	// failed assertions so far
	int assert_fails = 0;

	// nothing but nop during the power-up wait
	nop_before_pwr: assert property (@(posedge sys_clk) disable iff (!rstn)
		!pwr_up_done |-> cmd == sdram_cmd_pkg::NOP)
		else begin
			$error("command %b issued before power-up wait ended", cmd);
			assert_fails++;
		end

	// done is a single-cycle pulse
	done_one_cycle: assert property (@(posedge sys_clk) disable iff (!rstn)
		done |=> !done)
		else begin
			$error("done held longer than one cycle");
			assert_fails++;
		end

	// dq drive starts at activate of a write
	dq_start: assert property (@(posedge sys_clk) disable iff (!rstn)
		(dq_oe && !$past(dq_oe)) |-> (cmd == sdram_cmd_pkg::ACTIVE && wr_pend))
		else begin
			$error("dq driven outside a write activate");
			assert_fails++;
		end

	// released by the second cycle after write
	dq_release: assert property (@(posedge sys_clk) disable iff (!rstn)
		$past(cmd == sdram_cmd_pkg::WRITE, 2) |-> !dq_oe)
		else begin
			$error("dq still driven two cycles after write");
			assert_fails++;
		end

endmodule

bind sdram_cmd_engine sdram_subsys_assertions assertions_i (
	.sys_clk     (sys_clk),
	.rstn        (rstn),
	.pwr_up_done (pwr_up_done),
	.done        (req.done),
	.wr_pend     (req.wr_pend),
	.dq_oe       (dq_oe),
	.cmd         ({sdram_csn, sdram_rasn, sdram_casn, sdram_wen})
);

`default_nettype wire

// File: tb_sdram_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_subsys;

	localparam int init_cycles = 200;
	localparam int refresh_interval = 390;
	localparam int max_lines = 32;
	// inputs change this long after the rising edge
	localparam int drive_dly = 1;
	// idle tail long enough for one more periodic refresh
	localparam int idle_tail = refresh_interval + 20;

	logic        sys_clk;
	logic        rstn;
	logic [21:0] avl_addr;
	logic [1:0]  avl_byte_en;
	logic        avl_write;
	logic        avl_read;
	logic [15:0] avl_wrdata;
	logic [15:0] avl_rddata;
	logic        avl_waitrequest;
	logic        sdram_csn;
	logic        sdram_rasn;
	logic        sdram_casn;
	logic        sdram_wen;
	logic [1:0]  sdram_ba;
	logic [11:0] sdram_a;
	logic [1:0]  sdram_dqm;
	wire  [15:0] sdram_dq;

	logic [67:0] lines [max_lines];
	int n_acc;
	int limit;
	int cyc = 0;
	int data_errs;
	int proto_errs;
	int total_proto;

	sdram_subsys #(
		.init_cycles      (init_cycles),
		.refresh_interval (refresh_interval)
	) sdram_subsys_i (
		.sys_clk         (sys_clk),
		.rstn            (rstn),
		.avl_addr        (avl_addr),
		.avl_byte_en     (avl_byte_en),
		.avl_write       (avl_write),
		.avl_read        (avl_read),
		.avl_wrdata      (avl_wrdata),
		.avl_rddata      (avl_rddata),
		.avl_waitrequest (avl_waitrequest),
		.sdram_csn       (sdram_csn),
		.sdram_rasn      (sdram_rasn),
		.sdram_casn      (sdram_casn),
		.sdram_wen       (sdram_wen),
		.sdram_ba        (sdram_ba),
		.sdram_a         (sdram_a),
		.sdram_dq        (sdram_dq),
		.sdram_dqm       (sdram_dqm)
	);

	sdram_model model_i (
		.sys_clk (sys_clk),
		.csn     (sdram_csn),
		.rasn    (sdram_rasn),
		.casn    (sdram_casn),
		.wen     (sdram_wen),
		.ba      (sdram_ba),
		.a       (sdram_a),
		.dqm     (sdram_dqm),
		.dq      (sdram_dq)
	);

	tb_sdram_checker #(
		.init_cycles      (init_cycles),
		.refresh_interval (refresh_interval),
		.max_lines        (max_lines)
	) checker_i (
		.sys_clk         (sys_clk),
		.rstn            (rstn),
		.avl_addr        (avl_addr),
		.avl_byte_en     (avl_byte_en),
		.avl_write       (avl_write),
		.avl_read        (avl_read),
		.avl_rddata      (avl_rddata),
		.avl_waitrequest (avl_waitrequest),
		.cmd             ({sdram_csn, sdram_rasn, sdram_casn, sdram_wen}),
		.sdram_ba        (sdram_ba),
		.sdram_a         (sdram_a),
		.sdram_dqm       (sdram_dqm),
		.data_errs       (data_errs),
		.proto_errs      (proto_errs)
	);

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	// watchdog
	always @(posedge sys_clk) begin
		cyc = cyc + 1;
		if (cyc >= limit) begin
			$display("timeout: run stopped after %0d cycles with accesses unfinished", cyc);
			$display("Testbench failed");
			$finish;
		end
	end

	// hold one access until a rising edge sees waitrequest low
	task automatic run_access(input logic [67:0] ln);
		@(posedge sys_clk);
		#drive_dly;
		avl_addr = ln[57:36];
		avl_byte_en = ln[33:32];
		avl_wrdata = ln[31:16];
		avl_write = (ln[63:60] == 4'h1);
		avl_read = (ln[63:60] == 4'h2);
		do begin
			@(posedge sys_clk);
		end while (avl_waitrequest);
		#drive_dly;
		avl_write = 1'b0;
		avl_read = 1'b0;
	endtask

	initial begin
		rstn = 1'b0;
		avl_addr = '0;
		avl_byte_en = '0;
		avl_write = 1'b0;
		avl_read = 1'b0;
		avl_wrdata = '0;
		limit = 1 << 30;
		for (int i = 0; i < max_lines; i++) lines[i] = '0;
		$readmemh("sdram_testdata.txt", lines);
		// op 0 ends the list
		n_acc = 0;
		while (n_acc < max_lines && lines[n_acc][63:60] != 4'h0) n_acc++;
		limit = init_cycles + 50 + 40 * n_acc + 400;
		repeat (5) @(posedge sys_clk);
		#drive_dly;
		rstn = 1'b1;
		for (int i = 0; i < n_acc; i++) run_access(lines[i]);
		repeat (idle_tail) @(posedge sys_clk);
		total_proto = proto_errs + sdram_subsys_i.engine_i.assertions_i.assert_fails;
		$display("%0d accesses, %0d data errors, %0d protocol errors",
			n_acc, data_errs, total_proto);
		if (data_errs == 0 && total_proto == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sdram_subsys.f
sdram_cmd_pkg.sv
sdram_addr_pkg.sv
sdram_req_if.sv
avl_slave_port.sv
sdram_refresh_timer.sv
sdram_cmd_engine.sv
sdram_subsys.sv
sdram_model.sv
tb_sdram_checker.sv
sdram_subsys_assertions.sv
tb_sdram_subsys.sv

// File: sdram_testdata.txt
// columns: test id, op (1 write, 2 read), word address, byte enables,
// write data, expected read data
1_1_000010_3_1234_0000
1_2_000010_3_0000_1234
1_1_3ff0ff_3_beef_0000
1_2_3ff0ff_3_0000_beef
2_1_000020_3_aaaa_0000
2_1_000020_1_5555_0000
2_2_000020_3_0000_aa55
2_1_000020_2_1234_0000
2_2_000020_3_0000_1255
3_1_000040_3_1111_0000
3_1_100040_3_2222_0000
3_1_200040_3_3333_0000
3_1_0ab040_3_4444_0000
3_1_000041_3_5555_0000
3_2_000040_3_0000_1111
3_2_100040_3_0000_2222
3_2_200040_3_0000_3333
3_2_0ab040_3_0000_4444
3_2_000041_3_0000_5555
4_1_2a5c3e_3_c0de_0000
4_2_2a5c3e_3_0000_c0de
4_1_155a01_3_0f0f_0000
4_2_155a01_3_0000_0f0f
